// File: bench/regex_acc_tb.sv
`timescale 1ns/100ps

module regex_acc_tb
    import acc_mem_pkg::*, regex_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 200;
    localparam int STOP_CYCLES = 4;
    localparam time DRIVE_DELAY = 10;

    logic                       clk;
    logic                       rst;
    logic                       mem_wr_en;
    logic [PMEM_ADDR_WIDTH-1:0] mem_wr_addr;
    logic [DATA_WIDTH-1:0]      mem_wr_data;
    logic [STRB_WIDTH-1:0]      mem_wr_strb;
    logic [PMEM_ADDR_WIDTH-1:0] cmd_addr;
    logic [LEN_WIDTH-1:0]       cmd_len;
    logic                       cmd_valid;
    logic                       cmd_stop;
    logic                       cmd_ready;
    logic                       status_match;
    logic                       status_done;

    logic [31:0]                lfsr_state = 32'h252b88ed;
    int                         n_cmds;

    regex_acc_top uut (
        .clk(clk),
        .rst(rst),
        .mem_wr_en(mem_wr_en),
        .mem_wr_addr(mem_wr_addr),
        .mem_wr_data(mem_wr_data),
        .mem_wr_strb(mem_wr_strb),
        .cmd_addr(cmd_addr),
        .cmd_len(cmd_len),
        .cmd_valid(cmd_valid),
        .cmd_stop(cmd_stop),
        .cmd_ready(cmd_ready),
        .status_match(status_match),
        .status_done(status_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    // Inputs change and outputs are sampled a little after each rising edge
    task automatic tick();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_match(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch at %0t: status_match is %b, expected %b for %s",
                               $time, actual, expected, what));
        end
    endtask

    task automatic check_ready(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch at %0t: cmd_ready is %b, expected %b %s",
                               $time, actual, expected, what));
        end
    endtask

    task automatic check_done(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch at %0t: status_done is %b, expected %b %s",
                               $time, actual, expected, what));
        end
    endtask

    task automatic check_delay(input int actual, input int min_cycles, input int max_cycles,
                               input string what);
        if (actual < min_cycles || actual > max_cycles) begin
            fail_run($sformatf("Mismatch at %0t: status_done rose %0d cycles after %s, %s %0d to %0d",
                               $time, actual, what, "expected", min_cycles, max_cycles));
        end
    endtask

    // Galois form with taps at 32 22 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    task automatic pick_gap(output int n);
        n = 0;
        for (int i = 0; i < 3; i++) begin
            n = (n << 1) | lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (cmd_ready !== 1'b1) begin
            if (cycles == TIMEOUT_CYCLES) begin
                fail_run("Timeout: cmd_ready never went high within 200 cycles");
            end
            tick();
            cycles++;
        end
    endtask

    task automatic wait_done(output int cycles);
        cycles = 0;
        while (status_done !== 1'b1) begin
            if (cycles == TIMEOUT_CYCLES) begin
                fail_run("Timeout: status_done never went high within 200 cycles");
            end
            tick();
            cycles++;
        end
    endtask

    task automatic write_line(input logic [31:0] addr, input logic [31:0] data,
                              input logic [31:0] strb);
        mem_wr_en = 1'b1;
        mem_wr_addr = addr[PMEM_ADDR_WIDTH-1:0];
        mem_wr_data = data[DATA_WIDTH-1:0];
        mem_wr_strb = strb[STRB_WIDTH-1:0];
        tick();
        mem_wr_en = 1'b0;
    endtask

    // Leaves off one cycle after acceptance, when the old status is cleared
    task automatic issue_cmd(input logic [31:0] addr, input logic [31:0] len);
        int gap;
        pick_gap(gap);
        repeat (gap) tick();
        wait_ready();
        cmd_valid = 1'b1;
        cmd_addr = addr[PMEM_ADDR_WIDTH-1:0];
        cmd_len = len[LEN_WIDTH-1:0];
        tick();
        cmd_valid = 1'b0;
        check_ready(cmd_ready, 1'b0, "after a command was accepted");
        tick();
        check_done(status_done, 1'b0, "after a new command");
        check_match(status_match, 1'b0, "a freshly started scan");
        n_cmds++;
    endtask

    task automatic run_cmd(input logic [31:0] addr, input logic [31:0] len,
                           input logic expected);
        int waited;
        int scan_len;
        scan_len = (len == 0) ? 1 : len;
        issue_cmd(addr, len);
        wait_done(waited);
        // Done trails acceptance by the scanned length plus four cycles
        check_delay(waited + 1, scan_len + 4, scan_len + 4, "the command was accepted");
        check_ready(cmd_ready, 1'b1, "together with status_done");
        check_match(status_match, expected,
                    $sformatf("scan at 0x%h length %0d", addr[7:0], len));
    endtask

    task automatic run_stopped(input logic [31:0] addr, input logic [31:0] len,
                               input logic [31:0] gap);
        int waited;
        issue_cmd(addr, len);
        repeat (gap) tick();
        check_done(status_done, 1'b0, "before the stop");
        cmd_stop = 1'b1;
        tick();
        cmd_stop = 1'b0;
        wait_done(waited);
        check_delay(waited, 1, STOP_CYCLES, "cmd_stop");
        check_ready(cmd_ready, 1'b1, "after a stopped scan");
    endtask

    initial begin
        int                fd;
        int                code;
        logic [7:0]        kind;
        logic [31:0]       f1;
        logic [31:0]       f2;
        logic [31:0]       f3;
        logic [8*128-1:0]  comment_buf;

        rst = 1'b1;
        mem_wr_en = 1'b0;
        mem_wr_addr = '0;
        mem_wr_data = '0;
        mem_wr_strb = '0;
        cmd_addr = '0;
        cmd_len = '0;
        cmd_valid = 1'b0;
        cmd_stop = 1'b0;
        n_cmds = 0;

        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        check_done(status_done, 1'b0, "after reset");
        check_match(status_match, 1'b0, "the state after reset");
        check_ready(cmd_ready, 1'b0, "as reset ends");
        wait_ready();

        fd = $fopen("bench/regex_patterns.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open bench/regex_patterns.txt");
        end

        while ($fscanf(fd, " %c", kind) == 1) begin
            if (kind == "#") begin
                code = $fgets(comment_buf, fd);
            end else begin
                code = $fscanf(fd, "%h %h %h", f1, f2, f3);
                if (code != 3) begin
                    fail_run("A line of the pattern file has fewer than three fields");
                end
                case (kind)
                    "W": write_line(f1, f2, f3);
                    "C": run_cmd(f1, f2, f3[0]);
                    "S": run_stopped(f1, f2, f3);
                    default: fail_run($sformatf("Unknown line kind %c in pattern file", kind));
                endcase
            end
        end
        $fclose(fd);

        if (n_cmds == 0) begin
            fail_run("No commands were found in the pattern file");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// File: bench/regex_patterns.txt
# W byte_addr line_data strobe | C byte_addr length expected_match
# S byte_addr length cycles_before_stop (all fields hex)
W 00 63626261 f
W 04 62617878 f
W 08 78786362 f
W 0c 63626261 f
W 0c 00780000 4
W 10 61786361 f
W 14 63626262 f
W 80 63626178 f
W 84 62616363 f
W 88 78637862 f
C 00 4 1
C 0c 4 0
C 04 6 1
C 06 3 0
C 10 7 0
C 10 8 1
C 10 2 0
C 00 0 0
C 80 4 1
C 84 8 0
S 0c c 2
C 04 6 1
S 00 18 6
C 0c 4 0
C 00 18 1

// File: verilog.f
verilog/acc_mem_pkg.sv
verilog/regex_pkg.sv
verilog/re_matcher.sv
verilog/acc_mem_bank.sv
verilog/regex_acc.sv
verilog/regex_acc_top.sv
bench/regex_acc_tb.sv

// File: verilog/acc_mem_bank.sv
`timescale 1ns/100ps

module acc_mem_bank
    import acc_mem_pkg::*;
(
    input  logic                                 clk,

    input  logic                                 wr_en,
    input  logic [PMEM_SEL_BITS-1:0]             wr_sel,
    input  logic [ACC_ADDR_WIDTH-1:0]            wr_line,
    input  logic [DATA_WIDTH-1:0]                wr_data,
    input  logic [STRB_WIDTH-1:0]                wr_strb,

    input  logic [ACC_MEM_BLOCKS-1:0]            rd_en,
    input  logic [ACC_ADDR_WIDTH-1:0]            rd_line,
    output logic [ACC_MEM_BLOCKS*DATA_WIDTH-1:0] rd_data
);

    genvar b;

    for (b = 0; b < ACC_MEM_BLOCKS; b++) begin : g_blk
        logic [DATA_WIDTH-1:0] mem [2**ACC_ADDR_WIDTH];
        logic [DATA_WIDTH-1:0] rd_reg;

        // Host side writes bytes under strobe into the selected block
        always_ff @(posedge clk) begin
            if (wr_en && wr_sel == PMEM_SEL_BITS'(b)) begin
                for (int i = 0; i < STRB_WIDTH; i++) begin
                    if (wr_strb[i]) begin
                        mem[wr_line][i*8 +: 8] <= wr_data[i*8 +: 8];
                    end
                end
            end
        end

        // Read register holds its word while the enable is low
        always_ff @(posedge clk) begin
            if (rd_en[b]) begin
                rd_reg <= mem[rd_line];
            end
        end

        assign rd_data[b*DATA_WIDTH +: DATA_WIDTH] = rd_reg;
    end

endmodule

// File: verilog/acc_mem_pkg.sv
package acc_mem_pkg;

    // One packet-memory line and its byte lanes
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int LANE_BITS = $clog2(STRB_WIDTH);

    // Lines per block and blocks per bank
    localparam int ACC_ADDR_WIDTH = 4;
    localparam int PMEM_SEL_BITS = 1;
    localparam int ACC_MEM_BLOCKS = 2 ** PMEM_SEL_BITS;

    // Byte address is select, line, bank and lane from the top down
    localparam int PMEM_ADDR_WIDTH = PMEM_SEL_BITS + ACC_ADDR_WIDTH + 1 + LANE_BITS;

    // The flat view counts bytes, the field view steers the banks
    typedef union packed {
        logic [PMEM_ADDR_WIDTH-1:0] flat;
        struct packed {
            logic [PMEM_SEL_BITS-1:0]  sel;
            logic [ACC_ADDR_WIDTH-1:0] line;
            logic                      bank;
            logic [LANE_BITS-1:0]      lane;
        } fields;
    } pmem_addr_u;

endpackage

// File: verilog/re_matcher.sv
`timescale 1ns/100ps

module re_matcher
    import regex_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       restart,
    input  logic [7:0] data,
    input  logic       data_valid,
    output logic       match
);

    logic [1:0] state;
    logic [1:0] state_next;

    always_comb begin
        state_next = state;
        if (data_valid) begin
            case (state)
                DFA_HIT: begin
                    // Stays here until the next restart
                    state_next = DFA_HIT;
                end
                default: begin
                    if (data == PAT_FIRST) begin
                        state_next = DFA_GOT_A;
                    end else if (data == PAT_REPEAT &&
                                 (state == DFA_GOT_A || state == DFA_IN_B)) begin
                        state_next = DFA_IN_B;
                    end else if (data == PAT_LAST && state == DFA_IN_B) begin
                        state_next = DFA_HIT;
                    end else begin
                        state_next = DFA_IDLE;
                    end
                end
            endcase
        end
    end

    // Match is registered alongside the state it reports
    always_ff @(posedge clk) begin
        if (rst || restart) begin
            state <= DFA_IDLE;
            match <= 1'b0;
        end else begin
            state <= state_next;
            match <= (state_next == DFA_HIT);
        end
    end

endmodule

// File: verilog/regex_acc.sv
`timescale 1ns/100ps

module regex_acc
    import acc_mem_pkg::*, regex_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst,

    input  pmem_addr_u                         cmd_addr,
    input  logic [LEN_WIDTH-1:0]               cmd_len,
    input  logic                               cmd_valid,
    input  logic                               cmd_stop,
    output logic                               cmd_ready,

    output logic                               status_match,
    output logic                               status_done,

    output logic [ACC_MEM_BLOCKS-1:0]          acc_en_b1,
    output logic [ACC_ADDR_WIDTH-1:0]          acc_addr_b1,
    input  logic [ACC_MEM_BLOCKS*DATA_WIDTH-1:0] acc_rd_data_b1,

    output logic [ACC_MEM_BLOCKS-1:0]          acc_en_b2,
    output logic [ACC_ADDR_WIDTH-1:0]          acc_addr_b2,
    input  logic [ACC_MEM_BLOCKS*DATA_WIDTH-1:0] acc_rd_data_b2
);

    pmem_addr_u                          addr_reg;
    logic [LEN_WIDTH-1:0]                len_reg;
    logic                                rd_en_reg;
    logic                                scan_busy;
    logic                                start_reg;
    logic                                stop_reg;
    logic [DONE_STAGES-1:0]              fin_pipe;

    logic                                rd_valid_d;
    logic                                bank_d;
    logic [PMEM_SEL_BITS-1:0]            sel_d;
    logic [LANE_BITS-1:0]                lane_d;
    logic [ACC_MEM_BLOCKS*DATA_WIDTH-1:0] rd_word;
    logic [7:0]                          rd_byte;
    logic [7:0]                          byte_reg;
    logic                                byte_valid;

    logic [ACC_MEM_BLOCKS-1:0]           blk_onehot;
    logic                                accept;
    logic                                re_restart;
    logic                                re_match;

    // A stop in the same cycle as a valid command drops the command
    assign accept = cmd_valid && cmd_ready && !cmd_stop;

    // Only the bank named by the current address sees an enable
    assign blk_onehot = {{(ACC_MEM_BLOCKS-1){1'b0}}, 1'b1} << addr_reg.fields.sel;
    assign acc_en_b1 = (rd_en_reg && !addr_reg.fields.bank) ? blk_onehot : '0;
    assign acc_en_b2 = (rd_en_reg && addr_reg.fields.bank) ? blk_onehot : '0;
    assign acc_addr_b1 = addr_reg.fields.line;
    assign acc_addr_b2 = addr_reg.fields.line;

    // Read data comes back a cycle later, so pick it with the delayed fields
    assign rd_word = bank_d ? acc_rd_data_b2 : acc_rd_data_b1;
    assign rd_byte = rd_word[sel_d*DATA_WIDTH + lane_d*8 +: 8];

    assign re_restart = start_reg || stop_reg;

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_reg <= cmd_addr;
            // Zero length scans one byte
            len_reg <= (cmd_len == '0) ? LEN_WIDTH'(1) : cmd_len;
        end else if (rd_en_reg && len_reg > 1) begin
            addr_reg.flat <= addr_reg.flat + 1'b1;
            len_reg <= len_reg - 1'b1;
        end

        bank_d <= addr_reg.fields.bank;
        sel_d <= addr_reg.fields.sel;
        lane_d <= addr_reg.fields.lane;
        byte_reg <= rd_byte;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_ready <= 1'b0;
            status_match <= 1'b0;
            status_done <= 1'b0;
            rd_en_reg <= 1'b0;
            scan_busy <= 1'b0;
            start_reg <= 1'b0;
            stop_reg <= 1'b0;
            fin_pipe <= '0;
            rd_valid_d <= 1'b0;
            byte_valid <= 1'b0;
        end else begin
            start_reg <= accept;
            stop_reg <= cmd_stop;
            rd_valid_d <= rd_en_reg;
            byte_valid <= rd_valid_d;
            fin_pipe <= {fin_pipe[DONE_STAGES-2:0], 1'b0};

            if (cmd_stop) begin
                // Drop bytes in flight and finish through the done pipe
                rd_en_reg <= 1'b0;
                rd_valid_d <= 1'b0;
                byte_valid <= 1'b0;
                fin_pipe <= DONE_STAGES'(1);
            end else if (accept) begin
                rd_en_reg <= 1'b1;
                fin_pipe <= '0;
            end else if (rd_en_reg && len_reg <= 1) begin
                rd_en_reg <= 1'b0;
                fin_pipe <= {fin_pipe[DONE_STAGES-2:0], 1'b1};
            end

            if (accept) begin
                cmd_ready <= 1'b0;
                scan_busy <= 1'b1;
            end else if (fin_pipe[DONE_STAGES-1]) begin
                cmd_ready <= 1'b1;
                scan_busy <= 1'b0;
            end else if (!scan_busy) begin
                cmd_ready <= 1'b1;
            end

            if (start_reg) begin
                status_done <= 1'b0;
            end else if (fin_pipe[DONE_STAGES-1]) begin
                status_done <= 1'b1;
            end

            // The hit is sticky in the matcher, so status only needs to collect it
            if (start_reg) begin
                status_match <= 1'b0;
            end else if (re_match) begin
                status_match <= 1'b1;
            end
        end
    end

    re_matcher matcher (
        .clk(clk),
        .rst(rst),
        .restart(re_restart),
        .data(byte_reg),
        .data_valid(byte_valid),
        .match(re_match)
    );

endmodule

// File: verilog/regex_acc_top.sv
`timescale 1ns/100ps

module regex_acc_top
    import acc_mem_pkg::*, regex_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       mem_wr_en,
    input  logic [PMEM_ADDR_WIDTH-1:0] mem_wr_addr,
    input  logic [DATA_WIDTH-1:0]      mem_wr_data,
    input  logic [STRB_WIDTH-1:0]      mem_wr_strb,

    input  logic [PMEM_ADDR_WIDTH-1:0] cmd_addr,
    input  logic [LEN_WIDTH-1:0]       cmd_len,
    input  logic                       cmd_valid,
    input  logic                       cmd_stop,
    output logic                       cmd_ready,

    output logic                       status_match,
    output logic                       status_done
);

    pmem_addr_u                           wr_addr;
    logic [ACC_MEM_BLOCKS-1:0]            en_b1;
    logic [ACC_MEM_BLOCKS-1:0]            en_b2;
    logic [ACC_ADDR_WIDTH-1:0]            addr_b1;
    logic [ACC_ADDR_WIDTH-1:0]            addr_b2;
    logic [ACC_MEM_BLOCKS*DATA_WIDTH-1:0] rd_b1;
    logic [ACC_MEM_BLOCKS*DATA_WIDTH-1:0] rd_b2;

    // Lane bits of the host address are ignored, the bank bit picks the bank
    assign wr_addr.flat = mem_wr_addr;

    regex_acc acc (
        .clk(clk),
        .rst(rst),
        .cmd_addr(cmd_addr),
        .cmd_len(cmd_len),
        .cmd_valid(cmd_valid),
        .cmd_stop(cmd_stop),
        .cmd_ready(cmd_ready),
        .status_match(status_match),
        .status_done(status_done),
        .acc_en_b1(en_b1),
        .acc_addr_b1(addr_b1),
        .acc_rd_data_b1(rd_b1),
        .acc_en_b2(en_b2),
        .acc_addr_b2(addr_b2),
        .acc_rd_data_b2(rd_b2)
    );

    acc_mem_bank bank1 (
        .clk(clk),
        .wr_en(mem_wr_en && !wr_addr.fields.bank),
        .wr_sel(wr_addr.fields.sel),
        .wr_line(wr_addr.fields.line),
        .wr_data(mem_wr_data),
        .wr_strb(mem_wr_strb),
        .rd_en(en_b1),
        .rd_line(addr_b1),
        .rd_data(rd_b1)
    );

    acc_mem_bank bank2 (
        .clk(clk),
        .wr_en(mem_wr_en && wr_addr.fields.bank),
        .wr_sel(wr_addr.fields.sel),
        .wr_line(wr_addr.fields.line),
        .wr_data(mem_wr_data),
        .wr_strb(mem_wr_strb),
        .rd_en(en_b2),
        .rd_line(addr_b2),
        .rd_data(rd_b2)
    );

endmodule

// File: verilog/regex_pkg.sv
package regex_pkg;

    localparam int LEN_WIDTH = 16;

    // Cycles from the last bank read to status_done
    localparam int DONE_STAGES = 4;

    // The wired pattern is a, then one or more b, then c
    localparam logic [7:0] PAT_FIRST = 8'h61;
    localparam logic [7:0] PAT_REPEAT = 8'h62;
    localparam logic [7:0] PAT_LAST = 8'h63;

    // Matcher states
    localparam logic [1:0] DFA_IDLE = 2'd0;
    localparam logic [1:0] DFA_GOT_A = 2'd1;
    localparam logic [1:0] DFA_IN_B = 2'd2;
    localparam logic [1:0] DFA_HIT = 2'd3;

endpackage
